/* src.f */
+incdir+logic
logic/cache_pkg.sv
logic/way_lfsr.sv
logic/cache_way.sv
logic/hit_write_buffer.sv
logic/cache_ctrl.sv
logic/cache_top.sv
dv/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module cache_tb -f src.f -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0

/* dv/cache_tb.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_tb;

    localparam int ACCEPT_LIMIT = 200;
    localparam int DATA_LIMIT   = 200;
    localparam int DRAIN_LIMIT  = 200;
    localparam int NUM_REQ      = 800;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        valid;
    cache_pkg::cpu_req_t         req;
    logic                        addr_ok;
    logic                        data_ok;
    logic [`CACHE_WORD_W-1:0]    rdata;
    logic                        rd_req;
    logic [31:0]                 rd_addr;
    logic                        rd_rdy;
    logic                        ret_valid;
    logic                        ret_last;
    logic [`CACHE_WORD_W-1:0]    ret_data;
    logic                        wr_req;
    cache_pkg::wb_req_t          wb;
    logic                        wr_rdy;

    // bus-side memory and the value the CPU should see
    logic [31:0]  mem [64];
    logic [31:0]  ref_word [64];
    // per line write count and the count already covered by a write-back
    int           wr_marks [16];
    int           wb_seen [16];
    logic         touched [16];
    // refills per set and the set count at each line's last access
    int           set_fills [4];
    int           fill_stamp [16];
    logic [15:0]  cpu_rng;
    logic [15:0]  rsp_rng;
    logic [3:0]   last_rd_line;
    int           refills = 0;
    int           writebacks = 0;
    int           dok_count = 0;
    int           errors = 0;
    int           timeouts = 0;
    int           requests = 0;
    logic         aborted;

    always #20 clk = ~clk;

    cache_top i_cache_top (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wb        (wb),
        .wr_rdy    (wr_rdy)
    );

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_advance(input logic [15:0] s, input int n);
        logic [15:0] st;
        st = s;
        for (int i = 0; i < n; i++) begin
            st = {st[14:0], st[15] ^ st[13] ^ st[12] ^ st[10]};
        end
        return st;
    endfunction

    // key holds tag[1:0] index[1:0] bank[1:0]
    function automatic logic [31:0] word_addr(input logic [5:0] k);
        return {18'b0, k[5:4], 6'b0, k[3:2], k[1:0], 2'b00};
    endfunction

    function automatic logic [3:0] line_key(input logic [31:0] a);
        return {a[13:12], a[5:4]};
    endfunction

    function automatic logic [31:0] fill_word(input logic [5:0] k);
        return (word_addr(k) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [31:0] apply_strobes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] w;
        w = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                w[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return w;
    endfunction

    task automatic check_value(input string what, input logic [159:0] got,
                               input logic [159:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // one request from drive to data_ok
    // starts right after a rising edge
    task automatic run_request(input logic is_write, input logic [5:0] key,
                               input logic [3:0] strb, input logic [31:0] wdata);
        cache_pkg::cpu_req_t r;
        int                  wait_cycles;
        int                  refills_before;
        logic                accepted;
        logic                got;
        logic                must_hit;
        if (aborted) begin
            return;
        end
        r.op     = is_write ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
        r.tag    = {18'b0, key[5:4]};
        r.index  = {6'b0, key[3:2]};
        r.offset = {key[1:0], 2'b00};
        r.wstrb  = strb;
        r.wdata  = wdata;
        valid <= 1'b1;
        req   <= r;
        accepted = 1'b0;
        wait_cycles = 0;
        while (!accepted && wait_cycles < ACCEPT_LIMIT) begin
            @(posedge clk);
            wait_cycles++;
            accepted = valid && addr_ok;
        end
        valid <= 1'b0;
        if (!accepted) begin
            $display("timeout: request %0d was not accepted within %0d cycles",
                     requests, ACCEPT_LIMIT);
            timeouts++;
            aborted = 1'b1;
            return;
        end
        requests++;
        refills_before = refills;
        // a line stays resident until a refill reaches its set
        must_hit = touched[key[5:2]] && (fill_stamp[key[5:2]] == set_fills[key[3:2]]);
        if (is_write) begin
            ref_word[key] = apply_strobes(ref_word[key], wdata, strb);
            wr_marks[key[5:2]]++;
        end
        got = 1'b0;
        wait_cycles = 0;
        while (!got && wait_cycles < DATA_LIMIT) begin
            @(posedge clk);
            wait_cycles++;
            got = data_ok;
        end
        if (!got) begin
            $display("timeout: no data_ok for request %0d within %0d cycles",
                     requests, DATA_LIMIT);
            timeouts++;
            aborted = 1'b1;
            return;
        end
        if (!is_write) begin
            check_value("read data", 160'(rdata), 160'(ref_word[key]));
        end
        if (must_hit) begin
            check_value("refill of a resident line", 160'(refills), 160'(refills_before));
        end
        if (refills == refills_before) begin
            check_value("first access of a line without refill", 160'(touched[key[5:2]]),
                        160'(1'b1));
            check_value("hit latency", 160'(wait_cycles), 160'(1));
        end else begin
            check_value("refill line", 160'(last_rd_line), 160'(key[5:2]));
            set_fills[key[3:2]]++;
        end
        touched[key[5:2]] = 1'b1;
        fill_stamp[key[5:2]] = set_fills[key[3:2]];
    endtask

    // memory responder drives all bus inputs
    initial begin
        logic               wr_counting;
        logic [1:0]         wr_delay;
        logic               rd_counting;
        logic [1:0]         rd_delay;
        logic               returning;
        logic [3:0]         rd_line;
        logic [1:0]         beat_no;
        logic [1:0]         gap;
        logic [3:0]         wb_line;
        logic               prev_wr_wait;
        cache_pkg::wb_req_t prev_wb;
        wr_rdy    = 1'b0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        rsp_rng   = 16'd52;
        wr_counting  = 1'b0;
        wr_delay     = 2'd0;
        rd_counting  = 1'b0;
        rd_delay     = 2'd0;
        returning    = 1'b0;
        rd_line      = 4'd0;
        beat_no      = 2'd0;
        gap          = 2'd0;
        wb_line      = 4'd0;
        prev_wr_wait = 1'b0;
        prev_wb      = '0;
        last_rd_line = 4'd0;
        for (int k = 0; k < 64; k++) begin
            mem[k] = fill_word(6'(k));
        end
        for (int l = 0; l < 16; l++) begin
            wb_seen[l] = 0;
        end
        forever begin
            @(posedge clk);
            wr_rdy    <= 1'b0;
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (rst) begin
                wr_counting  = 1'b0;
                rd_counting  = 1'b0;
                returning    = 1'b0;
                prev_wr_wait = 1'b0;
            end else begin
                // a pending write-back must hold still
                if (prev_wr_wait) begin
                    check_value("wr_req dropped before wr_rdy", 160'(wr_req), 160'(1'b1));
                    check_value("wb changed before wr_rdy", wb, prev_wb);
                end
                prev_wr_wait = wr_req && !wr_rdy;
                prev_wb      = wb;

                if (wr_req && wr_rdy) begin
                    wb_line = line_key(wb.addr);
                    check_value("write-back address", 160'(wb.addr),
                                160'(word_addr({wb_line, 2'b00})));
                    check_value("write-back of a line never written",
                                160'(wr_marks[wb_line] != wb_seen[wb_line]), 160'(1'b1));
                    wb_seen[wb_line] = wr_marks[wb_line];
                    for (int b = 0; b < 4; b++) begin
                        check_value("write-back data", 160'(wb.data[b[1:0]]),
                                    160'(ref_word[{wb_line, b[1:0]}]));
                        mem[{wb_line, b[1:0]}] = wb.data[b[1:0]];
                    end
                    wr_counting = 1'b0;
                    writebacks++;
                end else if (wr_req) begin
                    if (!wr_counting) begin
                        rsp_rng     = lfsr_advance(rsp_rng, 2);
                        wr_delay    = rsp_rng[1:0];
                        wr_counting = 1'b1;
                    end
                    if (wr_delay == 2'd0) begin
                        wr_rdy <= 1'b1;
                    end else begin
                        wr_delay = wr_delay - 2'd1;
                    end
                end

                if (rd_req && rd_rdy) begin
                    rd_line = line_key(rd_addr);
                    check_value("refill address", 160'(rd_addr),
                                160'(word_addr({rd_line, 2'b00})));
                    last_rd_line = rd_line;
                    refills++;
                    rd_counting = 1'b0;
                    returning   = 1'b1;
                    beat_no     = 2'd0;
                    rsp_rng     = lfsr_advance(rsp_rng, 2);
                    gap         = rsp_rng[1:0];
                end else if (rd_req) begin
                    if (!rd_counting) begin
                        rsp_rng     = lfsr_advance(rsp_rng, 2);
                        rd_delay    = rsp_rng[1:0];
                        rd_counting = 1'b1;
                    end
                    if (rd_delay == 2'd0) begin
                        rd_rdy <= 1'b1;
                    end else begin
                        rd_delay = rd_delay - 2'd1;
                    end
                end

                // refill beats go out lowest word first
                if (returning) begin
                    if (gap == 2'd0) begin
                        ret_valid <= 1'b1;
                        ret_data  <= mem[{rd_line, beat_no}];
                        ret_last  <= (beat_no == 2'd3);
                        if (beat_no == 2'd3) begin
                            returning = 1'b0;
                        end
                        beat_no = beat_no + 2'd1;
                        rsp_rng = lfsr_advance(rsp_rng, 2);
                        gap     = rsp_rng[1:0];
                    end else begin
                        gap = gap - 2'd1;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && data_ok) begin
            dok_count <= dok_count + 1;
        end
    end

    // CPU side
    initial begin
        logic        is_write;
        logic [5:0]  key;
        logic [3:0]  strb;
        logic [31:0] wdata;
        int          refills_before;
        int          drain;
        rst     = 1'b1;
        valid   = 1'b0;
        req     = '0;
        aborted = 1'b0;
        cpu_rng = 16'd52;
        for (int k = 0; k < 64; k++) begin
            ref_word[k] = fill_word(6'(k));
        end
        for (int l = 0; l < 16; l++) begin
            wr_marks[l]   = 0;
            touched[l]    = 1'b0;
            fill_stamp[l] = 0;
        end
        for (int s = 0; s < 4; s++) begin
            set_fills[s] = 0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("addr_ok after reset", 160'(addr_ok), 160'(1'b1));
        check_value("rd_req after reset", 160'(rd_req), 160'(1'b0));
        check_value("wr_req after reset", 160'(wr_req), 160'(1'b0));
        check_value("data_ok after reset", 160'(data_ok), 160'(1'b0));

        // cold read and then another word of the same line
        refills_before = refills;
        run_request(1'b0, 6'h05, 4'h0, 32'h0);
        check_value("refills after cold read", 160'(refills), 160'(refills_before + 1));
        run_request(1'b0, 6'h06, 4'h0, 32'h0);
        check_value("refills after hit", 160'(refills), 160'(refills_before + 1));

        // partial write on a hit and then on a miss
        run_request(1'b1, 6'h05, 4'b0101, 32'hA1B2_C3D4);
        run_request(1'b0, 6'h05, 4'h0, 32'h0);
        run_request(1'b1, 6'h3A, 4'b1000, 32'h7E00_0000);
        run_request(1'b0, 6'h3A, 4'h0, 32'h0);

        for (int i = 0; i < NUM_REQ && !aborted; i++) begin
            cpu_rng  = lfsr_advance(cpu_rng, 1);
            is_write = cpu_rng[0];
            cpu_rng  = lfsr_advance(cpu_rng, 6);
            key      = cpu_rng[5:0];
            cpu_rng  = lfsr_advance(cpu_rng, 4);
            strb     = cpu_rng[3:0];
            cpu_rng  = lfsr_advance(cpu_rng, 16);
            wdata[15:0] = cpu_rng;
            cpu_rng  = lfsr_advance(cpu_rng, 16);
            wdata[31:16] = cpu_rng;
            cpu_rng  = lfsr_advance(cpu_rng, 2);
            if (cpu_rng[1:0] == 2'd0) begin
                @(posedge clk);
            end
            run_request(is_write, key, strb, wdata);
        end

        drain = 0;
        do begin
            @(posedge clk);
            drain++;
        end while (!addr_ok && drain < DRAIN_LIMIT);
        if (!addr_ok) begin
            $display("timeout: cache did not return to idle after the last request");
            timeouts++;
        end
        check_value("data_ok pulses per request", 160'(dok_count), 160'(requests));

        $display("errors %0d, timeouts %0d, requests %0d, refills %0d, write-backs %0d",
                 errors, timeouts, requests, refills, writebacks);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* logic/cache_top.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid,
    input  cache_pkg::cpu_req_t       req,
    output logic                      addr_ok,
    output logic                      data_ok,
    output logic [`CACHE_WORD_W-1:0]  rdata,
    output logic                      rd_req,
    output logic [31:0]               rd_addr,
    input  logic                      rd_rdy,
    input  logic                      ret_valid,
    input  logic                      ret_last,
    input  logic [`CACHE_WORD_W-1:0]  ret_data,
    output logic                      wr_req,
    output cache_pkg::wb_req_t        wb,
    input  logic                      wr_rdy
);

    cache_pkg::tagv_t                 way_tagv_0;
    cache_pkg::tagv_t                 way_tagv_1;
    logic                             way_dirty_0;
    logic                             way_dirty_1;
    cache_pkg::line_t                 way_line_0;
    cache_pkg::line_t                 way_line_1;
    logic [`CACHE_BANKS-1:0]          way_we_0;
    logic [`CACHE_BANKS-1:0]          way_we_1;
    logic                             way_tag_we_0;
    logic                             way_tag_we_1;
    logic                             way_dirty_val_0;
    logic                             way_dirty_val_1;
    logic [`CACHE_INDEX_W-1:0]        rd_index;
    logic [`CACHE_INDEX_W-1:0]        wr_index;
    logic [`CACHE_WORD_W-1:0]         bank_wdata;
    logic                             capture;
    logic                             cap_way;
    logic [`CACHE_INDEX_W-1:0]        cap_index;
    logic [`CACHE_OFFSET_W-3:0]       cap_bank;
    logic [`CACHE_STRB_W-1:0]         cap_wstrb;
    logic [`CACHE_WORD_W-1:0]         cap_wdata;
    logic [`CACHE_WORD_W-1:0]         cap_old;
    logic                             pending;
    logic                             wr_way;
    logic [`CACHE_INDEX_W-1:0]        buf_index;
    logic [`CACHE_OFFSET_W-3:0]       wr_bank;
    logic [`CACHE_WORD_W-1:0]         wr_word;
    logic                             rand_way;

    cache_ctrl i_cache_ctrl (.*);

    // tag and dirty are always written together
    // rd_addr carries the buffered request tag
    cache_way i_way_0 (
        .clk         (clk),
        .rst         (rst),
        .rd_index    (rd_index),
        .wr_index    (wr_index),
        .tagv        (way_tagv_0),
        .dirty       (way_dirty_0),
        .line        (way_line_0),
        .bank_we     (way_we_0),
        .tag_we      (way_tag_we_0),
        .tag_wdata   (rd_addr[31 -: `CACHE_TAG_W]),
        .dirty_we    (way_tag_we_0),
        .dirty_wdata (way_dirty_val_0),
        .bank_wdata  (bank_wdata)
    );

    cache_way i_way_1 (
        .clk         (clk),
        .rst         (rst),
        .rd_index    (rd_index),
        .wr_index    (wr_index),
        .tagv        (way_tagv_1),
        .dirty       (way_dirty_1),
        .line        (way_line_1),
        .bank_we     (way_we_1),
        .tag_we      (way_tag_we_1),
        .tag_wdata   (rd_addr[31 -: `CACHE_TAG_W]),
        .dirty_we    (way_tag_we_1),
        .dirty_wdata (way_dirty_val_1),
        .bank_wdata  (bank_wdata)
    );

    hit_write_buffer i_hit_write_buffer (.*);

    way_lfsr i_way_lfsr (.*);

endmodule

/* logic/cache_ctrl.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid,
    input  cache_pkg::cpu_req_t         req,
    output logic                        addr_ok,
    output logic                        data_ok,
    output logic [`CACHE_WORD_W-1:0]    rdata,
    output logic                        rd_req,
    output logic [31:0]                 rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  logic [`CACHE_WORD_W-1:0]    ret_data,
    output logic                        wr_req,
    output cache_pkg::wb_req_t          wb,
    input  logic                        wr_rdy,
    input  cache_pkg::tagv_t            way_tagv_0,
    input  cache_pkg::tagv_t            way_tagv_1,
    input  logic                        way_dirty_0,
    input  logic                        way_dirty_1,
    input  cache_pkg::line_t            way_line_0,
    input  cache_pkg::line_t            way_line_1,
    output logic [`CACHE_BANKS-1:0]     way_we_0,
    output logic [`CACHE_BANKS-1:0]     way_we_1,
    output logic                        way_tag_we_0,
    output logic                        way_tag_we_1,
    output logic                        way_dirty_val_0,
    output logic                        way_dirty_val_1,
    output logic [`CACHE_INDEX_W-1:0]   rd_index,
    output logic [`CACHE_INDEX_W-1:0]   wr_index,
    output logic [`CACHE_WORD_W-1:0]    bank_wdata,
    output logic                        capture,
    output logic                        cap_way,
    output logic [`CACHE_INDEX_W-1:0]   cap_index,
    output logic [`CACHE_OFFSET_W-3:0]  cap_bank,
    output logic [`CACHE_STRB_W-1:0]    cap_wstrb,
    output logic [`CACHE_WORD_W-1:0]    cap_wdata,
    output logic [`CACHE_WORD_W-1:0]    cap_old,
    input  logic                        pending,
    input  logic                        wr_way,
    input  logic [`CACHE_OFFSET_W-3:0]  wr_bank,
    input  logic [`CACHE_WORD_W-1:0]    wr_word,
    input  logic [`CACHE_INDEX_W-1:0]   buf_index,
    input  logic                        rand_way
);

    cache_pkg::main_state_e        state;
    cache_pkg::main_state_e        state_nxt;
    cache_pkg::cpu_req_t           req_q;
    logic [`CACHE_OFFSET_W-3:0]    bank_q;
    logic [`CACHE_OFFSET_W-3:0]    refill_cnt;
    logic                          replace_way;
    logic                          hit_0;
    logic                          hit_1;
    logic                          hit;
    logic [`CACHE_WORD_W-1:0]      hit_word;
    logic [`CACHE_WORD_W-1:0]      refill_word;
    logic                          refill_we;
    logic [`CACHE_BANKS-1:0]       bank_sel;
    cache_pkg::tagv_t              victim_tagv;
    logic                          victim_dirty;
    cache_pkg::line_t              victim_line;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::M_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::M_IDLE: begin
                if (valid && addr_ok) begin
                    state_nxt = cache_pkg::M_LOOKUP;
                end
            end
            cache_pkg::M_LOOKUP: begin
                state_nxt = hit ? cache_pkg::M_IDLE : cache_pkg::M_MISS;
            end
            cache_pkg::M_MISS: begin
                // clean or invalid victim skips the write-back
                if (!wr_req || wr_rdy) begin
                    state_nxt = cache_pkg::M_REPLACE;
                end
            end
            cache_pkg::M_REPLACE: begin
                if (rd_rdy) begin
                    state_nxt = cache_pkg::M_REFILL;
                end
            end
            cache_pkg::M_REFILL: begin
                if (ret_valid && ret_last) begin
                    state_nxt = cache_pkg::M_IDLE;
                end
            end
            default: begin
                state_nxt = cache_pkg::M_IDLE;
            end
        endcase
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            req_q <= req;
        end
    end

    assign bank_q = req_q.offset[`CACHE_OFFSET_W-1:2];

    // tag compare on the data read during acceptance
    assign hit_0    = way_tagv_0.valid && (way_tagv_0.tag == req_q.tag);
    assign hit_1    = way_tagv_1.valid && (way_tagv_1.tag == req_q.tag);
    assign hit      = hit_0 || hit_1;
    assign hit_word = hit_0 ? way_line_0[bank_q] : way_line_1[bank_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            replace_way <= 1'b0;
        end else if (state == cache_pkg::M_LOOKUP && !hit) begin
            replace_way <= rand_way;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            refill_cnt <= '0;
        end else if (refill_we) begin
            refill_cnt <= ret_last ? '0 : refill_cnt + 1'b1;
        end
    end

    // victim stays stable while the read index holds
    assign victim_tagv  = replace_way ? way_tagv_1 : way_tagv_0;
    assign victim_dirty = replace_way ? way_dirty_1 : way_dirty_0;
    assign victim_line  = replace_way ? way_line_1 : way_line_0;

    assign wr_req  = (state == cache_pkg::M_MISS) && victim_tagv.valid && victim_dirty;
    assign wb      = '{addr: {victim_tagv.tag, req_q.index, {`CACHE_OFFSET_W{1'b0}}},
                       data: victim_line};
    assign rd_req  = (state == cache_pkg::M_REPLACE);
    assign rd_addr = {req_q.tag, req_q.index, {`CACHE_OFFSET_W{1'b0}}};

    // write miss merges into its own beat
    assign refill_we   = (state == cache_pkg::M_REFILL) && ret_valid;
    assign refill_word = (req_q.op == cache_pkg::OP_WRITE && refill_cnt == bank_q) ?
                         cache_pkg::strb_merge(ret_data, req_q.wdata, req_q.wstrb) : ret_data;

    always_comb begin
        bank_sel = '0;
        bank_sel[refill_we ? refill_cnt : wr_bank] = 1'b1;
    end

    // refill and the buffered store never overlap
    assign way_we_0     = ((refill_we && !replace_way) || (pending && !wr_way)) ? bank_sel : '0;
    assign way_we_1     = ((refill_we && replace_way) || (pending && wr_way)) ? bank_sel : '0;
    assign way_tag_we_0 = (refill_we && ret_last && !replace_way) || (pending && !wr_way);
    assign way_tag_we_1 = (refill_we && ret_last && replace_way) || (pending && wr_way);

    // req_q still holds the write during a buffered store
    assign way_dirty_val_0 = (req_q.op == cache_pkg::OP_WRITE);
    assign way_dirty_val_1 = (req_q.op == cache_pkg::OP_WRITE);

    assign rd_index   = (state == cache_pkg::M_IDLE) ? req.index : req_q.index;
    assign wr_index   = pending ? buf_index : req_q.index;
    assign bank_wdata = pending ? wr_word : refill_word;

    assign capture   = (state == cache_pkg::M_LOOKUP) && hit && (req_q.op == cache_pkg::OP_WRITE);
    assign cap_way   = hit_1;
    assign cap_index = req_q.index;
    assign cap_bank  = bank_q;
    assign cap_wstrb = req_q.wstrb;
    assign cap_wdata = req_q.wdata;
    assign cap_old   = hit_word;

    assign addr_ok = (state == cache_pkg::M_IDLE) && !pending;
    assign data_ok = ((state == cache_pkg::M_LOOKUP) && hit) || (refill_we && refill_cnt == bank_q);
    assign rdata   = (state == cache_pkg::M_LOOKUP) ? hit_word : ret_data;

    // one data_ok per request, never two cycles in a row
    a_data_ok_pulse: assert property (@(posedge clk) disable iff (rst)
        data_ok |=> !data_ok);

    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wr_req && !wr_rdy |=> wr_req && $stable(wb));

    a_one_hit: assert property (@(posedge clk) disable iff (rst)
        (state == cache_pkg::M_LOOKUP) |-> !(hit_0 && hit_1));

endmodule

/* logic/hit_write_buffer.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module hit_write_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        capture,
    input  logic                        cap_way,
    input  logic [`CACHE_INDEX_W-1:0]   cap_index,
    input  logic [`CACHE_OFFSET_W-3:0]  cap_bank,
    input  logic [`CACHE_STRB_W-1:0]    cap_wstrb,
    input  logic [`CACHE_WORD_W-1:0]    cap_wdata,
    input  logic [`CACHE_WORD_W-1:0]    cap_old,
    output logic                        pending,
    output logic                        wr_way,
    output logic [`CACHE_INDEX_W-1:0]   buf_index,
    output logic [`CACHE_OFFSET_W-3:0]  wr_bank,
    output logic [`CACHE_WORD_W-1:0]    wr_word
);

    cache_pkg::wbuf_state_e        state;
    logic                          way_q;
    logic [`CACHE_INDEX_W-1:0]     index_q;
    logic [`CACHE_OFFSET_W-3:0]    bank_q;
    logic [`CACHE_WORD_W-1:0]      word_q;

    // store lasts exactly one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::W_IDLE;
        end else begin
            case (state)
                cache_pkg::W_IDLE:  state <= capture ? cache_pkg::W_WRITE : cache_pkg::W_IDLE;
                default:            state <= cache_pkg::W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            way_q   <= cap_way;
            index_q <= cap_index;
            bank_q  <= cap_bank;
            word_q  <= cache_pkg::strb_merge(cap_old, cap_wdata, cap_wstrb);
        end
    end

    assign pending   = (state == cache_pkg::W_WRITE);
    assign wr_way    = way_q;
    assign buf_index = index_q;
    assign wr_bank   = bank_q;
    assign wr_word   = word_q;

    a_no_capture_pending: assert property (@(posedge clk) disable iff (rst)
        capture |-> !pending);

endmodule

/* logic/cache_way.sv */
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_way (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`CACHE_INDEX_W-1:0]  rd_index,
    input  logic [`CACHE_INDEX_W-1:0]  wr_index,
    output cache_pkg::tagv_t           tagv,
    output logic                       dirty,
    output cache_pkg::line_t           line,
    input  logic [`CACHE_BANKS-1:0]    bank_we,
    input  logic                       tag_we,
    input  logic [`CACHE_TAG_W-1:0]    tag_wdata,
    input  logic                       dirty_we,
    input  logic                       dirty_wdata,
    input  logic [`CACHE_WORD_W-1:0]   bank_wdata
);

    localparam int SETS = 1 << `CACHE_INDEX_W;

    logic [`CACHE_TAG_W-1:0]   tag_mem [SETS];
    logic [`CACHE_WORD_W-1:0]  data_mem [`CACHE_BANKS][SETS];
    logic [SETS-1:0]           valid_q;
    logic [SETS-1:0]           dirty_q;
    logic [`CACHE_TAG_W-1:0]   tag_rd;
    logic                      valid_rd;
    logic                      dirty_rd;
    cache_pkg::line_t          line_rd;

    // tag and data arrays, one read and one write port
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[wr_index] <= tag_wdata;
        end
        tag_rd <= tag_mem[rd_index];
        for (int b = 0; b < `CACHE_BANKS; b++) begin
            if (bank_we[b]) begin
                data_mem[b][wr_index] <= bank_wdata;
            end
            line_rd[b] <= data_mem[b][rd_index];
        end
    end

    // valid is set by any tag write
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            valid_rd <= 1'b0;
            dirty_rd <= 1'b0;
        end else begin
            if (tag_we) begin
                valid_q[wr_index] <= 1'b1;
            end
            if (dirty_we) begin
                dirty_q[wr_index] <= dirty_wdata;
            end
            valid_rd <= valid_q[rd_index];
            dirty_rd <= dirty_q[rd_index];
        end
    end

    assign tagv  = '{tag: tag_rd, valid: valid_rd};
    assign dirty = dirty_rd;
    assign line  = line_rd;

endmodule

/* logic/way_lfsr.sv */
`timescale 1ns/10ps

module way_lfsr (
    input  logic clk,
    input  logic rst,
    output logic rand_way
);

    logic [7:0] lfsr_q;

    // taps 8,6,5,4 give the maximal 255-state sequence
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= 8'hA5;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    assign rand_way = lfsr_q[0];

    a_lfsr_nonzero: assert property (@(posedge clk) disable iff (rst) lfsr_q != 8'h00);

endmodule

/* logic/cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    typedef struct packed {
        cache_op_e                   op;
        logic [`CACHE_TAG_W-1:0]     tag;
        logic [`CACHE_INDEX_W-1:0]   index;
        logic [`CACHE_OFFSET_W-1:0]  offset;
        logic [`CACHE_STRB_W-1:0]    wstrb;
        logic [`CACHE_WORD_W-1:0]    wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0] tag;
        logic                    valid;
    } tagv_t;

    // bank 0 sits in the low word
    typedef logic [`CACHE_BANKS-1:0][`CACHE_WORD_W-1:0] line_t;

    typedef struct packed {
        logic [31:0] addr;
        line_t       data;
    } wb_req_t;

    // one-hot main FSM
    typedef enum logic [4:0] {
        M_IDLE    = 5'b00001,
        M_LOOKUP  = 5'b00010,
        M_MISS    = 5'b00100,
        M_REPLACE = 5'b01000,
        M_REFILL  = 5'b10000
    } main_state_e;

    typedef enum logic [1:0] {
        W_IDLE  = 2'b01,
        W_WRITE = 2'b10
    } wbuf_state_e;

    // new bytes over old bytes under the strobes
    function automatic logic [`CACHE_WORD_W-1:0] strb_merge(
        input logic [`CACHE_WORD_W-1:0] old_word,
        input logic [`CACHE_WORD_W-1:0] new_word,
        input logic [`CACHE_STRB_W-1:0] strb
    );
        logic [`CACHE_WORD_W-1:0] merged;
        merged = old_word;
        for (int i = 0; i < `CACHE_STRB_W; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

/* logic/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address split: tag | index | byte offset
`define CACHE_TAG_W     20
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  4

// one line is four 32-bit banks
`define CACHE_WORD_W    32
`define CACHE_BANKS     4
`define CACHE_LINE_W    128

// one strobe per byte
`define CACHE_STRB_W    4

`endif
